//--- design/aluControl.sv
`timescale 1ns/1ps

module aluControl #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                           soc_clk,
    input  logic                           reset,
    input  logic                           inValid,
    output logic                           inReady,
    input  logic [aluIsaPkg::OP_WIDTH-1:0] inOp,
    input  logic [DATA_WIDTH-1:0]          inA,
    input  logic [DATA_WIDTH-1:0]          inB,
    aluLaunchIf.ctrl                       arithLaunch,
    aluLaunchIf.ctrl                       shiftLaunch,
    aluLaunchIf.ctrl                       logicLaunch,
    input  logic [DATA_WIDTH-1:0]          arithResult,
    input  logic                           arithCarry,
    input  logic                           arithOverflow,
    input  logic                           arithDone,
    input  logic [DATA_WIDTH-1:0]          shiftResult,
    input  logic                           shiftDone,
    input  logic [DATA_WIDTH-1:0]          logicResult,
    input  logic                           logicDone,
    output logic                           outValid,
    input  logic                           outReady,
    output logic [DATA_WIDTH-1:0]          outResult,
    output aluStatusPkg::aluFlagsT         outFlags
);
    import aluIsaPkg::*;
    import aluStatusPkg::*;

    aluStateE              state;
    aluUnitE               unitSel;
    logic [OP_WIDTH-1:0]   opReg;
    logic [DATA_WIDTH-1:0] aReg;
    logic [DATA_WIDTH-1:0] bReg;
    logic [2:0]            launchVec;  // arith, shift, logic.
    logic [DATA_WIDTH-1:0] unitResult;
    aluFlagsT              unitFlags;

    assign inReady  = (state == IDLE);
    assign outValid = (state == HOLD);

    // operands are only captured on an accepted transfer.
    always_ff @(posedge soc_clk) begin
        if (inValid && inReady) begin
            opReg <= inOp;
            aReg  <= inA;
            bReg  <= inB;
        end
    end

    always_comb begin
        case (aluOpE'(opReg))
            OP_ADD, OP_SUB:         unitSel = UNIT_ARITH;
            OP_SLL, OP_SRL, OP_SRA: unitSel = UNIT_SHIFT;
            OP_AND, OP_OR, OP_XOR:  unitSel = UNIT_LOGIC;
            default:                unitSel = UNIT_NONE;
        endcase
    end

    // ========================================================================
    // launch
    // ========================================================================

    assign launchVec[2] = (state == LAUNCH) && (unitSel == UNIT_ARITH);
    assign launchVec[1] = (state == LAUNCH) && (unitSel == UNIT_SHIFT);
    assign launchVec[0] = (state == LAUNCH) && (unitSel == UNIT_LOGIC);

    assign arithLaunch.valid = launchVec[2];
    assign arithLaunch.op    = opReg;
    assign arithLaunch.a     = aReg;
    assign arithLaunch.b     = bReg;

    assign shiftLaunch.valid = launchVec[1];
    assign shiftLaunch.op    = opReg;
    assign shiftLaunch.a     = aReg;
    assign shiftLaunch.b     = bReg;

    assign logicLaunch.valid = launchVec[0];
    assign logicLaunch.op    = opReg;
    assign logicLaunch.a     = aReg;
    assign logicLaunch.b     = bReg;

    // ========================================================================
    // collect and flags
    // ========================================================================

    always_comb begin
        unitResult = '0;
        unitFlags  = '0;
        if (arithDone) begin
            unitResult         = arithResult;
            unitFlags.carry    = arithCarry;
            unitFlags.overflow = arithOverflow;
        end else if (shiftDone) begin
            unitResult = shiftResult;
        end else if (logicDone) begin
            unitResult = logicResult;
        end else begin
            unitFlags.illegal = 1'b1;  // no unit was launched.
        end
        unitFlags.zero     = (unitResult == '0);
        unitFlags.negative = unitResult[DATA_WIDTH-1];
    end

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            state     <= IDLE;
            outResult <= '0;
            outFlags  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (inValid) state <= LAUNCH;
                end
                LAUNCH:  state <= COLLECT;
                COLLECT: begin
                    outResult <= unitResult;
                    outFlags  <= unitFlags;
                    state     <= HOLD;
                end
                HOLD: begin
                    if (outReady) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    doneFollowsLaunch: assert property (@(posedge soc_clk) disable iff (reset)
        (|launchVec) |=> $onehot({arithDone, shiftDone, logicDone}));

    holdStable: assert property (@(posedge soc_clk) disable iff (reset)
        (outValid && !outReady) |=> ($stable(outResult) && $stable(outFlags)));

endmodule

//--- design/aluIsaPkg.sv
package aluIsaPkg;

    // ========================================================================
    // instruction set
    // ========================================================================

    localparam int OP_WIDTH = 4;

    // logic codes kept from the old logop block.
    typedef enum logic [OP_WIDTH-1:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_SLL = 4'd4,
        OP_SRL = 4'd5,
        OP_SRA = 4'd6,
        OP_XOR = 4'd11,
        OP_OR  = 4'd14,
        OP_AND = 4'd15
    } aluOpE;

    // which datapath unit an opcode goes to.
    typedef enum logic [1:0] {
        UNIT_ARITH = 2'd0,
        UNIT_SHIFT = 2'd1,
        UNIT_LOGIC = 2'd2,
        UNIT_NONE  = 2'd3
    } aluUnitE;

endpackage

//--- design/aluLaunchIf.sv
`timescale 1ns/1ps

interface aluLaunchIf #(
    parameter int DATA_WIDTH = 32
);
    import aluIsaPkg::*;

    logic                  valid;  // one cycle pulse.
    logic [OP_WIDTH-1:0]   op;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;

    // control side drives the launch.
    modport ctrl (
        output valid,
        output op,
        output a,
        output b
    );

    // datapath unit side.
    modport unit (
        input valid,
        input op,
        input a,
        input b
    );

endinterface

//--- design/aluStatusPkg.sv
package aluStatusPkg;

    // ========================================================================
    // status flags and control states
    // ========================================================================

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;     // add carry out, no borrow on sub.
        logic overflow;  // signed overflow.
        logic illegal;
    } aluFlagsT;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LAUNCH  = 2'd1,
        COLLECT = 2'd2,
        HOLD    = 2'd3
    } aluStateE;

endpackage

//--- design/aluTop.sv
`timescale 1ns/1ps

module aluTop #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                           soc_clk,
    input  logic                           reset,
    input  logic                           inValid,
    output logic                           inReady,
    input  logic [aluIsaPkg::OP_WIDTH-1:0] inOp,
    input  logic [DATA_WIDTH-1:0]          inA,
    input  logic [DATA_WIDTH-1:0]          inB,
    output logic                           outValid,
    input  logic                           outReady,
    output logic [DATA_WIDTH-1:0]          outResult,
    output aluStatusPkg::aluFlagsT         outFlags
);
    aluLaunchIf #(.DATA_WIDTH(DATA_WIDTH)) arithLaunch ();
    aluLaunchIf #(.DATA_WIDTH(DATA_WIDTH)) shiftLaunch ();
    aluLaunchIf #(.DATA_WIDTH(DATA_WIDTH)) logicLaunch ();

    logic [DATA_WIDTH-1:0] arithResult;
    logic                  arithCarry;
    logic                  arithOverflow;
    logic                  arithDone;
    logic [DATA_WIDTH-1:0] shiftResult;
    logic                  shiftDone;
    logic [DATA_WIDTH-1:0] logicResult;
    logic                  logicDone;

    aluControl #(.DATA_WIDTH(DATA_WIDTH)) ctrl0 (
        .soc_clk      (soc_clk),
        .reset        (reset),
        .inValid      (inValid),
        .inReady      (inReady),
        .inOp         (inOp),
        .inA          (inA),
        .inB          (inB),
        .arithLaunch  (arithLaunch),
        .shiftLaunch  (shiftLaunch),
        .logicLaunch  (logicLaunch),
        .arithResult  (arithResult),
        .arithCarry   (arithCarry),
        .arithOverflow(arithOverflow),
        .arithDone    (arithDone),
        .shiftResult  (shiftResult),
        .shiftDone    (shiftDone),
        .logicResult  (logicResult),
        .logicDone    (logicDone),
        .outValid     (outValid),
        .outReady     (outReady),
        .outResult    (outResult),
        .outFlags     (outFlags)
    );

    // ========================================================================
    // datapath units
    // ========================================================================

    arithUnit #(.DATA_WIDTH(DATA_WIDTH)) arith0 (
        .soc_clk (soc_clk),
        .reset   (reset),
        .launch  (arithLaunch),
        .result  (arithResult),
        .carry   (arithCarry),
        .overflow(arithOverflow),
        .done    (arithDone)
    );

    shiftUnit #(.DATA_WIDTH(DATA_WIDTH)) shift0 (
        .soc_clk(soc_clk),
        .reset  (reset),
        .launch (shiftLaunch),
        .result (shiftResult),
        .done   (shiftDone)
    );

    logicUnit #(.DATA_WIDTH(DATA_WIDTH)) logic0 (
        .soc_clk(soc_clk),
        .reset  (reset),
        .launch (logicLaunch),
        .result (logicResult),
        .done   (logicDone)
    );

endmodule

//--- design/arithUnit.sv
`timescale 1ns/1ps

module arithUnit #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  soc_clk,
    input  logic                  reset,
    aluLaunchIf.unit              launch,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  carry,
    output logic                  overflow,
    output logic                  done
);
    import aluIsaPkg::*;

    localparam int MSB = DATA_WIDTH - 1;

    logic                  isSub;
    logic [DATA_WIDTH-1:0] bIn;
    logic [DATA_WIDTH:0]   sum;
    logic                  sumOverflow;

    // sub is a + ~b + 1 on the same adder.
    assign isSub = (aluOpE'(launch.op) == OP_SUB);
    assign bIn   = isSub ? ~launch.b : launch.b;
    assign sum   = {1'b0, launch.a} + {1'b0, bIn} + {{DATA_WIDTH{1'b0}}, isSub};

    // same operand signs, different result sign.
    assign sumOverflow = (launch.a[MSB] == bIn[MSB]) && (sum[MSB] != launch.a[MSB]);

    always_ff @(posedge soc_clk) begin
        if (launch.valid) begin
            result   <= sum[MSB:0];
            carry    <= sum[DATA_WIDTH];
            overflow <= sumOverflow;
        end
    end

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= launch.valid;
        end
    end

    arithOpOnly: assert property (@(posedge soc_clk) disable iff (reset)
        launch.valid |-> (aluOpE'(launch.op) inside {OP_ADD, OP_SUB}));

endmodule

//--- design/logicUnit.sv
`timescale 1ns/1ps

module logicUnit #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  soc_clk,
    input  logic                  reset,
    aluLaunchIf.unit              launch,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  done
);
    import aluIsaPkg::*;

    // result holds between launches.
    always_ff @(posedge soc_clk) begin
        if (launch.valid) begin
            case (aluOpE'(launch.op))
                OP_AND:  result <= launch.a & launch.b;
                OP_OR:   result <= launch.a | launch.b;
                OP_XOR:  result <= launch.a ^ launch.b;
                default: result <= '0;
            endcase
        end
    end

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= launch.valid;
        end
    end

    // control only routes logic codes here.
    logicOpOnly: assert property (@(posedge soc_clk) disable iff (reset)
        launch.valid |-> (aluOpE'(launch.op) inside {OP_AND, OP_OR, OP_XOR}));

endmodule

//--- design/shiftUnit.sv
`timescale 1ns/1ps

module shiftUnit #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  soc_clk,
    input  logic                  reset,
    aluLaunchIf.unit              launch,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  done
);
    import aluIsaPkg::*;

    localparam int SH_WIDTH = $clog2(DATA_WIDTH);

    logic [SH_WIDTH-1:0] amount;

    assign amount = launch.b[SH_WIDTH-1:0];  // upper bits of b ignored.

    always_ff @(posedge soc_clk) begin
        if (launch.valid) begin
            case (aluOpE'(launch.op))
                OP_SLL:  result <= launch.a << amount;
                OP_SRL:  result <= launch.a >> amount;
                OP_SRA:  result <= $signed(launch.a) >>> amount;
                default: result <= '0;
            endcase
        end
    end

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= launch.valid;
        end
    end

endmodule

//--- dv/aluTb.sv
`timescale 1ns/1ps

module aluTb;
    import aluIsaPkg::*;
    import aluStatusPkg::*;

    localparam int DATA_WIDTH    = 32;
    localparam int SH_WIDTH      = $clog2(DATA_WIDTH);
    localparam int RESET_CYCLES  = 5;
    localparam int LATENCY       = 3;   // cycles from accept edge to outValid seen.
    localparam int ROW_CYCLES    = 20;
    localparam int RANDOM_ROWS   = 40;
    localparam logic [31:0] SEED = 32'h1b12_627b;

    logic                  soc_clk;
    logic                  reset;
    logic                  inValid;
    logic                  inReady;
    logic [OP_WIDTH-1:0]   inOp;
    logic [DATA_WIDTH-1:0] inA;
    logic [DATA_WIDTH-1:0] inB;
    logic                  outValid;
    logic                  outReady;
    logic [DATA_WIDTH-1:0] outResult;
    aluFlagsT              outFlags;

    // stimulus table, one entry per transaction.
    string                 rowName[$];
    logic [OP_WIDTH-1:0]   rowOp[$];
    logic [DATA_WIDTH-1:0] rowA[$];
    logic [DATA_WIDTH-1:0] rowB[$];
    logic [DATA_WIDTH-1:0] rowRes[$];
    aluFlagsT              rowFlags[$];
    int                    rowHold[$];   // cycles of outReady low.

    int   valueErrors    = 0;
    int   protocolErrors = 0;
    int   inCount        = 0;
    int   acceptCount    = 0;
    logic lastInReady    = 1'b0;
    logic tableReady     = 1'b0;

    aluTop #(.DATA_WIDTH(DATA_WIDTH)) dut0 (
        .soc_clk  (soc_clk),
        .reset    (reset),
        .inValid  (inValid),
        .inReady  (inReady),
        .inOp     (inOp),
        .inA      (inA),
        .inB      (inB),
        .outValid (outValid),
        .outReady (outReady),
        .outResult(outResult),
        .outFlags (outFlags)
    );

    initial begin
        soc_clk = 1'b0;
        forever #2 soc_clk = ~soc_clk;
    end

    // ========================================================================
    // reference model
    // ========================================================================

    function automatic void expectedFor(input logic [OP_WIDTH-1:0] op,
                                        input logic [DATA_WIDTH-1:0] a,
                                        input logic [DATA_WIDTH-1:0] b,
                                        output logic [DATA_WIDTH-1:0] res,
                                        output aluFlagsT flg);
        logic [DATA_WIDTH:0] wide;
        res  = '0;
        flg  = '0;
        wide = '0;
        case (aluOpE'(op))
            OP_ADD: begin
                wide         = {1'b0, a} + {1'b0, b};
                res          = wide[DATA_WIDTH-1:0];
                flg.carry    = wide[DATA_WIDTH];
                flg.overflow = (a[DATA_WIDTH-1] == b[DATA_WIDTH-1]) &&
                               (res[DATA_WIDTH-1] != a[DATA_WIDTH-1]);
            end
            OP_SUB: begin
                res          = a - b;
                flg.carry    = (a >= b);   // no borrow.
                flg.overflow = (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]) &&
                               (res[DATA_WIDTH-1] != a[DATA_WIDTH-1]);
            end
            OP_SLL:  res = a << b[SH_WIDTH-1:0];
            OP_SRL:  res = a >> b[SH_WIDTH-1:0];
            OP_SRA:  res = $signed(a) >>> b[SH_WIDTH-1:0];
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            default: flg.illegal = 1'b1;
        endcase
        flg.zero     = (res == '0);
        flg.negative = res[DATA_WIDTH-1];
    endfunction

    task automatic addRow(input string name, input logic [OP_WIDTH-1:0] op,
                          input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                          input logic [DATA_WIDTH-1:0] res, input aluFlagsT flg,
                          input int hold);
        rowName.push_back(name);
        rowOp.push_back(op);
        rowA.push_back(a);
        rowB.push_back(b);
        rowRes.push_back(res);
        rowFlags.push_back(flg);
        rowHold.push_back(hold);
    endtask

    // flags column reads zero, negative, carry, overflow, illegal.
    task automatic buildTable();
        logic [OP_WIDTH-1:0]   op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] res;
        aluFlagsT              flg;
        addRow("and",        OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200, 5'b00000, 0);
        addRow("or",         OP_OR,  32'hF000_0000, 32'h0000_000F, 32'hF000_000F, 5'b01000, 2);
        addRow("xorSelf",    OP_XOR, 32'hA5A5_A5A5, 32'hA5A5_A5A5, 32'h0000_0000, 5'b10000, 0);
        addRow("xor",        OP_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F, 5'b01000, 1);
        addRow("addOvf",     OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000, 5'b01010, 0);
        addRow("addCarry",   OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000, 5'b10100, 3);
        addRow("addSmall",   OP_ADD, 32'h0000_0003, 32'h0000_0004, 32'h0000_0007, 5'b00000, 0);
        addRow("subOvf",     OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h7FFF_FFFF, 5'b00110, 0);
        addRow("subSelf",    OP_SUB, 32'h1234_5678, 32'h1234_5678, 32'h0000_0000, 5'b10100, 0);
        addRow("subBorrow",  OP_SUB, 32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE, 5'b01000, 1);
        addRow("sll0",       OP_SLL, 32'h8000_0001, 32'd0,         32'h8000_0001, 5'b01000, 0);
        addRow("sll1",       OP_SLL, 32'h8000_0001, 32'd1,         32'h0000_0002, 5'b00000, 0);
        addRow("sll31",      OP_SLL, 32'h0000_0003, 32'd31,        32'h8000_0000, 5'b01000, 0);
        addRow("sllHighB",   OP_SLL, 32'h0000_0001, 32'd33,        32'h0000_0002, 5'b00000, 0);
        addRow("srl1",       OP_SRL, 32'h8000_0000, 32'd1,         32'h4000_0000, 5'b00000, 0);
        addRow("srl31",      OP_SRL, 32'h8000_0000, 32'd31,        32'h0000_0001, 5'b00000, 2);
        addRow("sra0",       OP_SRA, 32'hF000_0000, 32'd0,         32'hF000_0000, 5'b01000, 0);
        addRow("sra1",       OP_SRA, 32'h8000_0000, 32'd1,         32'hC000_0000, 5'b01000, 0);
        addRow("sra31",      OP_SRA, 32'h8000_0000, 32'd31,        32'hFFFF_FFFF, 5'b01000, 0);
        addRow("sraPos31",   OP_SRA, 32'h7FFF_FFFF, 32'd31,        32'h0000_0000, 5'b10000, 0);
        addRow("illegal2",   4'd2,   32'h0000_1234, 32'h0000_0005, 32'h0000_0000, 5'b10001, 0);
        addRow("illegal7",   4'd7,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 5'b10001, 1);
        addRow("illegal12",  4'd12,  32'h8000_0000, 32'h0000_0001, 32'h0000_0000, 5'b10001, 0);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            op = 4'($urandom_range(0, 15));
            a  = $urandom();
            b  = $urandom();
            expectedFor(op, a, b, res, flg);
            addRow($sformatf("rand%0d", i), op, a, b, res, flg, int'($urandom_range(0, 5)));
        end
    endtask

    // ========================================================================
    // transaction
    // ========================================================================

    task automatic runRow(input int idx);
        logic [DATA_WIDTH-1:0] heldResult;
        aluFlagsT              heldFlags;
        int                    latency;
        @(posedge soc_clk);
        inValid <= 1'b1;
        inOp    <= rowOp[idx];
        inA     <= rowA[idx];
        inB     <= rowB[idx];
        @(negedge soc_clk);
        while (!inReady) @(negedge soc_clk);
        @(posedge soc_clk);   // accept edge.
        inValid <= 1'b0;
        latency = 0;
        do begin
            @(negedge soc_clk);
            latency++;
            if (inReady && !outValid) begin
                protocolErrors++;
                $display("inReady went high before the result of %s", rowName[idx]);
            end
        end while (!outValid);
        if (latency != LATENCY) begin
            protocolErrors++;
            $display("Fail %s: latency expected %0d actual %0d", rowName[idx], LATENCY, latency);
        end
        if (outResult != rowRes[idx]) begin
            valueErrors++;
            $display("Fail %s: result expected %h actual %h", rowName[idx], rowRes[idx], outResult);
        end
        if (outFlags != rowFlags[idx]) begin
            valueErrors++;
            $display("Fail %s: flags expected %b actual %b", rowName[idx], rowFlags[idx], outFlags);
        end
        heldResult = outResult;
        heldFlags  = outFlags;
        repeat (rowHold[idx]) begin
            @(posedge soc_clk);
            @(negedge soc_clk);
            if (!outValid || inReady) begin
                protocolErrors++;
                $display("handshake state changed while %s was held back", rowName[idx]);
            end
            if (outResult != heldResult || outFlags != heldFlags) begin
                valueErrors++;
                $display("Fail %s: held output expected %h/%b actual %h/%b", rowName[idx],
                         heldResult, heldFlags, outResult, outFlags);
            end
        end
        @(posedge soc_clk);
        outReady <= 1'b1;
        @(posedge soc_clk);   // result taken here.
        outReady <= 1'b0;
        @(negedge soc_clk);
        if (outValid || !inReady) begin
            protocolErrors++;
            $display("ALU did not return to idle after %s was taken", rowName[idx]);
        end
    endtask

    // an input counts when the ALU leaves idle.
    always @(negedge soc_clk) begin
        if (!reset) begin
            if (lastInReady && !inReady) inCount++;
            if (outValid && outReady) acceptCount++;
        end
        lastInReady = inReady;
    end

    initial begin
        wait (tableReady == 1'b1);
        repeat (rowName.size() * ROW_CYCLES + RESET_CYCLES) @(posedge soc_clk);
        $display("watchdog expired, the ALU stopped responding");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        inValid  = 1'b0;
        inOp     = '0;
        inA      = '0;
        inB      = '0;
        outReady = 1'b0;
        void'($urandom(SEED));
        buildTable();
        tableReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge soc_clk);
        reset <= 1'b0;
        @(negedge soc_clk);
        if (!inReady || outValid || outResult != '0 || outFlags != '0) begin
            protocolErrors++;
            $display("outputs are not in their reset state after reset");
        end
        for (int i = 0; i < rowName.size(); i++) begin
            runRow(i);
        end
        @(negedge soc_clk);
        if (inCount != rowName.size() || acceptCount != rowName.size()) begin
            protocolErrors++;
            $display("%0d inputs accepted and %0d results taken for %0d rows",
                     inCount, acceptCount, rowName.size());
        end
        $display("rows %0d, value errors %0d, protocol errors %0d",
                 rowName.size(), valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -sv \
    --timescale 1ns/1ps \
    --top-module aluTb \
    -f vlog.f \
    -o aluSim

./obj_dir/aluSim | tee sim.log

if grep -q ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- vlog.f
design/aluIsaPkg.sv
design/aluStatusPkg.sv
design/aluLaunchIf.sv
design/arithUnit.sv
design/shiftUnit.sv
design/logicUnit.sv
design/aluControl.sv
design/aluTop.sv
dv/aluTb.sv
